/* Bender.yml */
package:
  name: pdp8_core

sources:
  - src/pdp8_pkg.sv
  - src/panel_switches.sv
  - src/major_state.sv
  - src/mem_addr.sv
  - src/accum.sv
  - src/pdp8_core.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/pdp8_chk.sv
      - dv/pdp8_tb.sv

/* build.f */
src/pdp8_pkg.sv
src/panel_switches.sv
src/major_state.sv
src/mem_addr.sv
src/accum.sv
src/pdp8_core.sv
dv/clk_gen.sv
dv/pdp8_chk.sv
dv/pdp8_tb.sv

/* dv/clk_gen.sv */
// Free-running 8 ns clock; reset is held low for the first 4 rising edges only.
`timescale 1ns/100ps

module clk_gen
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1; // released just after the fourth edge.
    end

endmodule

/* dv/pdp8_chk.sv */
// Checks major-state sequencing and the run lamp only; the datapath is checked by the testbench.
`timescale 1ns/100ps

module pdp8_chk
(
    input logic             clk,
    input logic             rst_n,
    input pdp8_pkg::major_t state,
    input logic             cont_p,
    input logic             run
);
    import pdp8_pkg::*;

    int fails = 0;

    halted_until_cont: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == HALTED) && !cont_p) |=> (state == HALTED))
    else
    begin
        fails++;
        $error("state left HALTED without a continue pulse");
    end

    // a defer cycle is only reached straight from fetch.
    defer_after_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        (state != FETCH) |=> (state != DEFER))
    else
    begin
        fails++;
        $error("DEFER entered from a state other than FETCH");
    end

    run_low_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
        (state == HALTED) |-> !run)
    else
    begin
        fails++;
        $error("run lamp is on while the machine is halted");
    end

endmodule

/* dv/pdp8_tb.sv */
// Key presses assume a 16-cycle debounce; core words are only compared after they were deposited.
`timescale 1ns/100ps

module pdp8_tb;
    import pdp8_pkg::*;

    localparam int KEY_LOAD        = 0;
    localparam int KEY_DEP         = 1;
    localparam int KEY_EXAM        = 2;
    localparam int KEY_CONT        = 3;
    localparam int KEY_HALT        = 4;
    localparam int KEY_STEP        = 5;
    localparam int KEY_HOLD        = DEBOUNCE_CYCLES + 8;
    localparam int TESTS           = 6;
    localparam int CYCLES_PER_TEST = 2000;

    logic       clk;
    logic       rst_n;
    word_t      sr;
    logic [5:0] keys_n;
    word_t      ac_lamps;
    logic       link_lamp;
    addr_t      pc_lamps;
    word_t      mb_lamps;
    logic       run;

    word_t m_mem [MEM_WORDS];
    addr_t m_pc;
    word_t m_ac;
    logic  m_link;
    word_t blk [$];
    logic  want_hlt;
    logic  want_one;
    int    run_cycles;
    int    run_falls;
    int    errors;
    int    checks;
    int    seed;

    clk_gen u_clk (.clk, .rst_n);

    pdp8_core DUT (.clk, .rst_n, .sr, .addr_loadn (keys_n[KEY_LOAD]), .depn (keys_n[KEY_DEP]),
                   .examn (keys_n[KEY_EXAM]), .contn (keys_n[KEY_CONT]),
                   .haltn (keys_n[KEY_HALT]), .single_stepn (keys_n[KEY_STEP]), .ac_lamps,
                   .link_lamp, .pc_lamps, .mb_lamps, .run);

    bind major_state pdp8_chk u_chk (.clk, .rst_n, .state, .cont_p, .run);

    task automatic check_value(input logic [11:0] got, input logic [11:0] exp,
                               input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %o, expected %o", $time, what, got, exp);
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic press_key(input int key);
        keys_n[key] = 1'b0;
        repeat (KEY_HOLD) next_edge(); // long enough to pass the debounce filter.
        keys_n[key] = 1'b1;
        repeat (KEY_HOLD) next_edge();
    endtask

    task automatic load_addr(input addr_t a);
        sr   = a;
        m_pc = a;
        press_key(KEY_LOAD);
        check_value(pc_lamps, m_pc, "pc after address load");
    endtask

    task automatic deposit(input word_t w);
        sr = w;
        press_key(KEY_DEP);
        m_mem[m_pc] = w;
        m_pc        = m_pc + 1'b1;
        check_value(mb_lamps, w, "mb after deposit");
        check_value(pc_lamps, m_pc, "pc after deposit");
    endtask

    task automatic examine();
        press_key(KEY_EXAM);
        check_value(mb_lamps, m_mem[m_pc], "mb after examine");
        m_pc = m_pc + 1'b1;
        check_value(pc_lamps, m_pc, "pc after examine");
    endtask

    task automatic deposit_block(input addr_t start);
        load_addr(start);
        foreach (blk[i])
            deposit(blk[i]);
    endtask

    // the halt key, when used, goes down while the program is running.
    task automatic continue_run(input logic hlt, input logic one, input logic use_halt);
        int seen;
        seen     = run_falls;
        want_hlt = hlt;
        want_one = one;
        press_key(KEY_CONT);
        if (use_halt)
            keys_n[KEY_HALT] = 1'b0;
        wait (run_falls != seen);
        next_edge();
        if (use_halt)
        begin
            keys_n[KEY_HALT] = 1'b1;
            repeat (KEY_HOLD) next_edge();
        end
    endtask

    function automatic void operate_group1(input word_t op);
        logic rb;
        if (op[CLA_BIT])
            m_ac = '0;
        if (op[CLL_BIT])
            m_link = 1'b0;
        if (op[CMA_BIT])
            m_ac = ~m_ac;
        if (op[CML_BIT])
            m_link = ~m_link;
        if (op[IAC_BIT])
        begin
            m_ac = m_ac + 1'b1;
            if (m_ac == '0)
                m_link = ~m_link; // carry out of ac.
        end
        if (op[ROR_BIT])
            repeat (op[TWICE_BIT] ? 2 : 1)
            begin
                rb     = m_ac[11];
                m_ac   = {m_link, m_ac[0:10]};
                m_link = rb;
            end
        if (op[ROL_BIT])
            repeat (op[TWICE_BIT] ? 2 : 1)
            begin
                rb     = m_ac[0];
                m_ac   = {m_ac[1:11], m_link};
                m_link = rb;
            end
    endfunction

    // runs one instruction of the model and returns how many major states it needs.
    function automatic int model_step(output logic hlt);
        word_t       instr;
        word_t       ea;
        logic [12:0] sum;
        logic        defer;
        instr = m_mem[m_pc];
        ea    = {instr[CUR_BIT] ? m_pc[0:4] : 5'b0, instr[5:11]};
        defer = (instr[0:2] != OP_IOT) && (instr[0:2] != OP_OPR) && instr[IND_BIT];
        hlt   = 1'b0;
        m_pc  = m_pc + 1'b1;
        if (defer)
            ea = m_mem[ea];
        case (instr[0:2])
            OP_AND: m_ac = m_ac & m_mem[ea];
            OP_TAD:
            begin
                sum    = {1'b0, m_ac} + {1'b0, m_mem[ea]};
                m_ac   = sum[11:0];
                m_link = m_link ^ sum[12];
            end
            OP_ISZ:
            begin
                m_mem[ea] = m_mem[ea] + 1'b1;
                if (m_mem[ea] == '0)
                    m_pc = m_pc + 1'b1;
            end
            OP_DCA:
            begin
                m_mem[ea] = m_ac;
                m_ac      = '0;
            end
            OP_JMS:
            begin
                m_mem[ea] = m_pc;
                m_pc      = ea + 1'b1;
            end
            OP_JMP: m_pc = ea;
            OP_OPR:
            begin
                if (!instr[GRP_BIT])
                    operate_group1(instr);
                else
                    hlt = !instr[SUBGRP_BIT] && instr[HLT_BIT];
            end
            default: hlt = 1'b0;
        endcase
        return defer ? 3 : 2;
    endfunction

    task automatic check_run(input int cycles);
        int   used;
        int   n;
        logic hlt;
        used = 0;
        n    = 0;
        hlt  = 1'b0;
        while ((used < cycles) && !hlt)
        begin
            used += model_step(hlt);
            n++;
        end
        if ((used != cycles) || (hlt != want_hlt) || (want_one && (n != 1)))
        begin
            errors++;
            $display("run of %0d cycles at %0t does not match the model (%0d instructions)",
                     cycles, $time, n);
        end
        check_value(ac_lamps, m_ac, "ac after run");
        check_value(link_lamp, m_link, "link after run");
        check_value(pc_lamps, m_pc, "pc after run");
    endtask

    // run length is counted on the falling clock edge, where the lamps are stable.
    always @(negedge clk)
    begin
        if (run)
            run_cycles++;
        else if (run_cycles != 0)
        begin
            check_run(run_cycles);
            run_cycles = 0;
            run_falls++;
        end
    end

    initial
    begin
        repeat (TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout after %0d cycles, the console sequence never completed",
                 TESTS * CYCLES_PER_TEST);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        seed       = 91;
        errors     = 0;
        checks     = 0;
        run_cycles = 0;
        run_falls  = 0;
        want_hlt   = 1'b0;
        want_one   = 1'b0;
        sr         = '0;
        keys_n     = '1;
        m_pc       = '0;
        m_ac       = '0;
        m_link     = 1'b0;
        wait (rst_n);
        next_edge();

        blk.delete();
        repeat (8)
            blk.push_back(word_t'($random(seed)));
        deposit_block(12'o0400);
        load_addr(12'o0400);
        repeat (8)
            examine();

        // main line, loop on ISZ, then JMS through page zero into a subroutine.
        blk = '{12'o7300, 12'o1250, 12'o0251, 12'o3252, 12'o1253, 12'o2254, 12'o5204,
                12'o3255, 12'o4420, 12'o7402};
        deposit_block(12'o0200);
        blk = '{12'o0000, 12'o1252, 12'o7041, 12'o1250, 12'o3257, 12'o5630};
        deposit_block(12'o0230);
        blk = '{12'o0123, 12'o0077, 12'o0000, 12'o0007, 12'o7774, 12'o0000, 12'o0000,
                12'o0000};
        deposit_block(12'o0250);
        blk = '{12'o0230};
        deposit_block(12'o0020);
        load_addr(12'o0200);
        continue_run(1'b1, 1'b0, 1'b0);
        load_addr(12'o0230);
        examine();
        load_addr(12'o0252);
        repeat (6)
            examine();

        repeat (4)
        begin
            blk.delete();
            blk.push_back(($random(seed) & 1) ? 12'o7320 : 12'o7300);
            blk.push_back(12'o1304);
            blk.push_back(12'o7000 | word_t'($random(seed) & 'o377));
            blk.push_back(12'o7402);
            blk.push_back(word_t'($random(seed)));
            deposit_block(12'o0300);
            load_addr(12'o0300);
            continue_run(1'b1, 1'b0, 1'b0);
        end

        keys_n[KEY_STEP] = 1'b0;
        repeat (KEY_HOLD) next_edge();
        load_addr(12'o0200);
        repeat (8)
            continue_run(1'b0, 1'b1, 1'b0);
        keys_n[KEY_STEP] = 1'b1;
        repeat (KEY_HOLD) next_edge();

        blk = '{12'o1306, 12'o2307, 12'o5300, 12'o7402, 12'o0000, 12'o0000, 12'o0005,
                12'o7000};
        deposit_block(12'o0300);
        load_addr(12'o0300);
        continue_run(1'b0, 1'b0, 1'b1);

        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 DUT.u_state.u_chk.fails);
        errors += DUT.u_state.u_chk.fails;
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* src/accum.sv */
// Group 1 operate only; both rotate bits together rotate right first, then left.
`timescale 1ns/100ps

module accum
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            exec,
    input  pdp8_pkg::word_t ir,
    input  pdp8_pkg::word_t mdata,
    output pdp8_pkg::word_t ac,
    output logic            link
);
    import pdp8_pkg::*;

    opcode_t     opcode;
    logic [12:0] tad_sum;
    logic [12:0] lv;
    word_t       opr_ac;
    logic        opr_link;

    assign opcode  = ir[0:2];
    assign tad_sum = {1'b0, ac} + {1'b0, mdata};

    // link and ac form one 13-bit register, link on top.
    always_comb
    begin
        lv = {link, ac};
        if (ir[CLA_BIT])
            lv[11:0] = '0;
        if (ir[CLL_BIT])
            lv[12] = 1'b0;
        if (ir[CMA_BIT])
            lv[11:0] = ~lv[11:0];
        if (ir[CML_BIT])
            lv[12] = ~lv[12];
        if (ir[IAC_BIT])
            lv = lv + 13'd1; // carry out of ac complements link.
        if (ir[ROR_BIT])
        begin
            lv = {lv[0], lv[12:1]};
            if (ir[TWICE_BIT])
                lv = {lv[0], lv[12:1]};
        end
        if (ir[ROL_BIT])
        begin
            lv = {lv[11:0], lv[12]};
            if (ir[TWICE_BIT])
                lv = {lv[11:0], lv[12]};
        end
        opr_link = lv[12];
        opr_ac   = lv[11:0];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ac   <= '0;
            link <= 1'b0;
        end
        else if (exec)
        begin
            case (opcode)
                OP_AND: ac <= ac & mdata;
                OP_TAD:
                begin
                    ac   <= tad_sum[11:0];
                    link <= link ^ tad_sum[12];
                end
                OP_DCA: ac <= '0; // the store itself happens in mem_addr.
                OP_OPR:
                begin
                    if (!ir[GRP_BIT])
                    begin
                        ac   <= opr_ac;
                        link <= opr_link;
                    end
                end
                default: ac <= ac;
            endcase
        end
    end

endmodule

/* src/major_state.sv */
// One clock per major state; console keys act only while halted, interrupts are not supported.
`timescale 1ns/100ps

module major_state
(
    input  logic             clk,
    input  logic             rst_n,
    input  pdp8_pkg::word_t  ir,
    input  logic             cont_p,
    input  logic             halt_lvl,
    input  logic             step_lvl,
    input  logic             addr_load_p,
    input  logic             dep_p,
    input  logic             exam_p,
    output pdp8_pkg::major_t state,
    output logic             ir_load,
    output logic             ma_ind,
    output logic             exec,
    output logic             panel_load,
    output logic             panel_dep,
    output logic             panel_exam,
    output logic             run
);
    import pdp8_pkg::*;

    opcode_t opcode;
    logic    stopped;
    logic    mem_ref;
    logic    indirect;
    logic    is_hlt;
    logic    stop_req;

    assign opcode  = ir[0:2];
    assign stopped = (state == HALTED);

    assign panel_load = addr_load_p & stopped;
    assign panel_dep  = dep_p & stopped;
    assign panel_exam = exam_p & stopped;

    assign ir_load = (state == FETCH);
    assign ma_ind  = (state == DEFER);
    assign exec    = (state == EXEC);

    // during fetch ir already shows the word coming out of core.
    assign mem_ref  = (opcode != OP_IOT) && (opcode != OP_OPR);
    assign indirect = mem_ref & ir[IND_BIT];

    assign is_hlt = (opcode == OP_OPR) & ir[GRP_BIT] & ~ir[SUBGRP_BIT] & ir[HLT_BIT];

    // single step stops after every instruction, the halt key does the same.
    assign stop_req = is_hlt | halt_lvl | step_lvl;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= HALTED;
            run   <= 1'b0;
        end
        else
        begin
            case (state)
                HALTED:
                begin
                    if (cont_p)
                    begin
                        state <= FETCH;
                        run   <= 1'b1;
                    end
                end
                FETCH:
                begin
                    state <= indirect ? DEFER : EXEC;
                end
                DEFER:
                begin
                    state <= EXEC;
                end
                EXEC:
                begin
                    if (stop_req)
                    begin
                        state <= HALTED;
                        run   <= 1'b0; // run falls together with the halt.
                    end
                    else
                        state <= FETCH;
                end
                default:
                begin
                    state <= HALTED;
                    run   <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* src/mem_addr.sv */
// 4K core with combinational read and no auto-index; core contents are undefined until deposited.
`timescale 1ns/100ps

module mem_addr
(
    input  logic            clk,
    input  logic            rst_n,
    input  pdp8_pkg::word_t sr,
    input  logic            ir_load,
    input  logic            ma_ind,
    input  logic            exec,
    input  logic            panel_load,
    input  logic            panel_dep,
    input  logic            panel_exam,
    input  pdp8_pkg::word_t ac,
    output pdp8_pkg::word_t ir,
    output pdp8_pkg::word_t mdata,
    output pdp8_pkg::addr_t pc,
    output pdp8_pkg::word_t mb_lamps
);
    import pdp8_pkg::*;

    word_t   core [MEM_WORDS];
    addr_t   ma;
    word_t   ir_q;
    opcode_t opcode;
    page_t   page;
    addr_t   eaddr;
    addr_t   pc_inc;
    addr_t   ma_inc;
    word_t   isz_val;
    logic    mem_we;
    word_t   mem_wdata;

    // ma follows pc whenever a fetch or a console action is due.
    assign mdata   = core[ma];
    assign ir      = ir_load ? mdata : ir_q; // forwarded so the sequencer sees the indirect bit.
    assign opcode  = ir_q[0:2];
    assign page    = mdata[CUR_BIT] ? ma[0:4] : '0;
    assign eaddr   = {page, mdata[5:11]};
    assign pc_inc  = pc + 12'd1;
    assign ma_inc  = ma + 12'd1;
    assign isz_val = mdata + 12'd1;

    always_comb
    begin
        mem_we    = 1'b0;
        mem_wdata = sr;
        if (panel_dep)
            mem_we = 1'b1;
        else if (exec)
        begin
            case (opcode)
                OP_ISZ: {mem_we, mem_wdata} = {1'b1, isz_val};
                OP_DCA: {mem_we, mem_wdata} = {1'b1, ac};
                OP_JMS: {mem_we, mem_wdata} = {1'b1, pc}; // return address.
                default: mem_we = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_we)
            core[ma] <= mem_wdata;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= '0;
            ma <= '0;
            ir_q <= '0;
            mb_lamps <= '0;
        end
        else if (panel_load)
            {pc, ma} <= {sr, sr};
        else if (panel_dep)
            {pc, ma, mb_lamps} <= {pc_inc, pc_inc, sr};
        else if (panel_exam)
            {pc, ma, mb_lamps} <= {pc_inc, pc_inc, mdata};
        else if (ir_load)
            {pc, ma, ir_q, mb_lamps} <= {pc_inc, eaddr, mdata, mdata};
        else if (ma_ind)
            {ma, mb_lamps} <= {mdata, mdata};
        else if (exec)
        begin
            mb_lamps <= mem_we ? mem_wdata : mdata;
            case (opcode)
                OP_ISZ: {pc, ma} <= (isz_val == '0) ? {pc_inc, pc_inc} : {pc, pc};
                OP_JMS: {pc, ma} <= {ma_inc, ma_inc}; // body starts after the link word.
                OP_JMP: pc <= ma;
                default: ma <= pc;
            endcase
        end
    end

endmodule

/* src/panel_switches.sv */
// Switches are active low and asynchronous; a change is seen after 2 sync plus 16 stable cycles.
`timescale 1ns/100ps

module panel_switches
(
    input  logic clk,
    input  logic rst_n,
    input  logic addr_loadn,
    input  logic depn,
    input  logic examn,
    input  logic contn,
    input  logic haltn,
    input  logic single_stepn,
    output logic addr_load_p,
    output logic dep_p,
    output logic exam_p,
    output logic cont_p,
    output logic halt_lvl,
    output logic step_lvl
);
    import pdp8_pkg::*;

    logic [5:0]          raw_n;
    logic [5:0]          sync_1;
    logic [5:0]          sync_2;
    logic [5:0]          level;
    logic [5:0]          level_d;
    logic [3:0]          press;
    logic [DB_CNT_W-1:0] cnt [6];

    // bits 0 to 3 are momentary keys, 4 and 5 are held levels.
    assign raw_n = {single_stepn, haltn, contn, examn, depn, addr_loadn};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_1 <= '0;
            sync_2 <= '0;
        end
        else
        begin
            sync_1 <= ~raw_n; // convert to active high here.
            sync_2 <= sync_1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            level <= '0;
            for (int i = 0; i < 6; i++)
                cnt[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < 6; i++)
            begin
                if (sync_2[i] == level[i])
                    cnt[i] <= '0; // bounce back to the old level restarts the count.
                else if (cnt[i] == DB_CNT_W'(DEBOUNCE_CYCLES - 1))
                begin
                    level[i] <= sync_2[i];
                    cnt[i]   <= '0;
                end
                else
                    cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            level_d <= '0;
            press   <= '0;
        end
        else
        begin
            level_d <= level;
            press   <= level[3:0] & ~level_d[3:0]; // one pulse per accepted press.
        end
    end

    assign addr_load_p = press[0];
    assign dep_p       = press[1];
    assign exam_p      = press[2];
    assign cont_p      = press[3];
    assign halt_lvl    = level[4];
    assign step_lvl    = level[5];

endmodule

/* src/pdp8_core.sv */
// Single 4K field, no IOT devices or interrupts; sr is sampled directly without a register.
`timescale 1ns/100ps

module pdp8_core
(
    input  logic            clk,
    input  logic            rst_n,
    input  pdp8_pkg::word_t sr,
    input  logic            addr_loadn,
    input  logic            depn,
    input  logic            examn,
    input  logic            contn,
    input  logic            haltn,
    input  logic            single_stepn,
    output pdp8_pkg::word_t ac_lamps,
    output logic            link_lamp,
    output pdp8_pkg::addr_t pc_lamps,
    output pdp8_pkg::word_t mb_lamps,
    output logic            run
);
    import pdp8_pkg::*;

    logic  addr_load_p, dep_p, exam_p, cont_p, halt_lvl, step_lvl;
    logic  ir_load, ma_ind, exec, panel_load, panel_dep, panel_exam;
    word_t ir;
    word_t mdata;

    panel_switches u_switches (.clk, .rst_n, .addr_loadn, .depn, .examn, .contn, .haltn,
                               .single_stepn, .addr_load_p, .dep_p, .exam_p, .cont_p,
                               .halt_lvl, .step_lvl);

    // the major state stays inside the sequencer.
    major_state u_state (.clk, .rst_n, .ir, .cont_p, .halt_lvl, .step_lvl, .addr_load_p,
                         .dep_p, .exam_p, .state (), .ir_load, .ma_ind, .exec, .panel_load,
                         .panel_dep, .panel_exam, .run);

    mem_addr u_mem (.clk, .rst_n, .sr, .ir_load, .ma_ind, .exec, .panel_load, .panel_dep,
                    .panel_exam, .ac (ac_lamps), .ir, .mdata, .pc (pc_lamps), .mb_lamps);

    accum u_accum (.clk, .rst_n, .exec, .ir, .mdata, .ac (ac_lamps), .link (link_lamp));

endmodule

/* src/pdp8_pkg.sv */
// Types and constants for the reduced PDP-8/e; bit 0 is the MSB of every word, IF/DF not modeled.
package pdp8_pkg;

    // data word, numbered from the most significant bit as on the PDP-8.
    typedef logic [0:11] word_t;

    // memory address within the single 4K field.
    typedef logic [0:11] addr_t;

    // page number, the upper five address bits.
    typedef logic [0:4] page_t;

    // major opcode, instruction bits 0 to 2.
    typedef logic [0:2] opcode_t;

    typedef enum logic [1:0]
    {
        FETCH,
        DEFER,
        EXEC,
        HALTED
    } major_t;

    localparam opcode_t OP_AND = 3'o0;
    localparam opcode_t OP_TAD = 3'o1;
    localparam opcode_t OP_ISZ = 3'o2;
    localparam opcode_t OP_DCA = 3'o3;
    localparam opcode_t OP_JMS = 3'o4;
    localparam opcode_t OP_JMP = 3'o5;
    localparam opcode_t OP_IOT = 3'o6; // decoded as a no-op.
    localparam opcode_t OP_OPR = 3'o7;

    // memory-reference address fields.
    localparam int IND_BIT = 3;
    localparam int CUR_BIT = 4;

    // operate group selection.
    localparam int GRP_BIT    = 3;  // 0 selects group 1.
    localparam int SUBGRP_BIT = 11; // must be 0 for group 2.

    // group 1 microinstructions.
    localparam int CLA_BIT   = 4;
    localparam int CLL_BIT   = 5;
    localparam int CMA_BIT   = 6;
    localparam int CML_BIT   = 7;
    localparam int ROR_BIT   = 8;
    localparam int ROL_BIT   = 9;
    localparam int TWICE_BIT = 10;
    localparam int IAC_BIT   = 11;

    // group 2 halt.
    localparam int HLT_BIT = 10;

    // a switch must hold its new level this many cycles to be accepted.
    localparam int DEBOUNCE_CYCLES = 16;
    localparam int DB_CNT_W        = 5;

    localparam int MEM_WORDS = 4096;

endpackage
